/* fix_defines.svh */
// Word format, queue depths, credit widths and FIX byte codes
`ifndef FIX_DEFINES_SVH
`define FIX_DEFINES_SVH

// Word layout: lane 3 in bits 31:24 holds the earliest byte
`define FIX_WORD_W 32
`define FIX_LANES 4
`define FIX_POS_W 3

// Flow control
`define FIX_IN_CREDITS 4 // Also the input queue depth
`define FIX_FQ_DEPTH 4
`define FIX_OUT_CREDITS_W 3

// Byte codes
`define FIX_SOH 8'h01
`define FIX_SEP 8'h3D // '='
`define FIX_NO_POS 3'b111

`endif

/* fix_pkg.sv */
// Parse state enum, split word struct and field record struct
`include "fix_defines.svh"

package fix_pkg;

	// Which part of a field the next byte belongs to
	typedef enum logic {
		ST_TAG = 1'b0,
		ST_VALUE = 1'b1
	} fix_state_e;

	// One input word after lane classification
	typedef struct packed {
		logic [`FIX_WORD_W-1:0] data;
		logic [`FIX_LANES-1:0] tag_mask;
		logic [`FIX_LANES-1:0] value_mask;
		logic [`FIX_LANES-1:0] soh_lane; // One-hot, zero when no SOH
		fix_state_e exit_state;
	} fix_lanes_t;

	// One finished field
	typedef struct packed {
		logic [15:0] tag; // Decimal tag, saturates at 16'hFFFF
		logic tag_err; // Non-digit byte seen in the tag
		logic [7:0] value_len;
		logic [7:0] value_sum; // Sum of value bytes mod 256
	} fix_field_t;

endpackage

/* fix_delim_detect.sv */
// SOH and '=' lane position encoder with duplicate delimiter flag
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_delim_detect (
	input logic [`FIX_WORD_W-1:0] word_i,
	output logic [`FIX_POS_W-1:0] soh_pos_o,
	output logic [`FIX_POS_W-1:0] sep_pos_o,
	output logic bad_o
);

	logic [`FIX_LANES-1:0] soh_hit;
	logic [`FIX_LANES-1:0] sep_hit;

	// Lane index of the highest set bit, or the no-position code
	function automatic logic [`FIX_POS_W-1:0] enc_pos(input logic [`FIX_LANES-1:0] hit);
		logic [`FIX_POS_W-1:0] pos;
		pos = `FIX_NO_POS;
		for (int i = 0; i < `FIX_LANES; i++) begin
			if (hit[i]) begin
				pos = i[`FIX_POS_W-1:0];
			end
		end
		return pos;
	endfunction

	always_comb begin
		for (int i = 0; i < `FIX_LANES; i++) begin
			soh_hit[i] = (word_i[i*8 +: 8] == `FIX_SOH);
			sep_hit[i] = (word_i[i*8 +: 8] == `FIX_SEP);
		end
	end

	assign soh_pos_o = enc_pos(soh_hit);
	assign sep_pos_o = enc_pos(sep_hit);

	// More than one bit set in either hit vector
	assign bad_o = ((soh_hit & (soh_hit - 1'b1)) != '0) ||
		((sep_hit & (sep_hit - 1'b1)) != '0);

endmodule

/* fix_lane_splitter.sv */
// Lane classifier into tag, value and SOH lanes with exit state
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_lane_splitter (
	input logic [`FIX_WORD_W-1:0] word_i,
	input logic [`FIX_POS_W-1:0] soh_pos_i,
	input logic [`FIX_POS_W-1:0] sep_pos_i,
	input fix_pkg::fix_state_e state_i,
	output fix_pkg::fix_lanes_t lanes_o
);

	logic [`FIX_LANES-1:0] soh_hot;
	logic [`FIX_LANES-1:0] sep_hot;
	logic [`FIX_LANES-1:0] tag_mask;
	logic [`FIX_LANES-1:0] value_mask;
	fix_pkg::fix_state_e exit_state;

	// No-position code maps to an all-zero vector
	function automatic logic [`FIX_LANES-1:0] pos_to_hot(input logic [`FIX_POS_W-1:0] pos);
		logic [`FIX_LANES-1:0] hot;
		hot = '0;
		for (int i = 0; i < `FIX_LANES; i++) begin
			if (int'(pos) == i) begin
				hot[i] = 1'b1;
			end
		end
		return hot;
	endfunction

	assign soh_hot = pos_to_hot(soh_pos_i);
	assign sep_hot = pos_to_hot(sep_pos_i);

	// Examples
	//   "35=A" from ST_TAG: tag 3..2, sep at 1, value at 0, exit ST_VALUE
	//   "9\x0110" from ST_VALUE: value at 3, SOH at 2, tag 1..0, exit ST_TAG
	// With no delimiter every lane takes the entry state
	always_comb begin : walk
		fix_pkg::fix_state_e st;
		st = state_i;
		tag_mask = '0;
		value_mask = '0;
		for (int i = `FIX_LANES - 1; i >= 0; i--) begin
			if (soh_hot[i]) begin
				st = fix_pkg::ST_TAG; // Field closes, next byte starts a tag
			end else if (sep_hot[i]) begin
				st = fix_pkg::ST_VALUE;
			end else if (st == fix_pkg::ST_TAG) begin
				tag_mask[i] = 1'b1;
			end else begin
				value_mask[i] = 1'b1;
			end
		end
		exit_state = st;
	end

	always_comb begin
		lanes_o.data = word_i;
		lanes_o.tag_mask = tag_mask;
		lanes_o.value_mask = value_mask;
		lanes_o.soh_lane = soh_hot;
		lanes_o.exit_state = exit_state;
	end

endmodule

/* fix_field_builder.sv */
// Tag and value accumulator folding lanes into a field record queue
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_field_builder (
	input logic clk_i,
	input logic rst_n_i,
	input fix_pkg::fix_lanes_t lanes_i,
	input logic take_i,
	input logic send_i,
	output logic fq_room_o,
	output fix_pkg::fix_field_t fq_head_o,
	output logic fq_empty_o
);

	localparam int PTR_W = $clog2(`FIX_FQ_DEPTH);

	fix_pkg::fix_field_t acc_q;
	fix_pkg::fix_field_t acc_nxt;
	fix_pkg::fix_field_t push_rec;
	logic push;

	fix_pkg::fix_field_t fq_mem [`FIX_FQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] fq_cnt;

	// Lanes fold from 3 down to 0; the SOH lane closes the record
	always_comb begin : fold
		logic [7:0] lane_byte;
		logic [19:0] tag_wide;
		acc_nxt = acc_q;
		push = 1'b0;
		push_rec = acc_q;
		for (int i = `FIX_LANES - 1; i >= 0; i--) begin
			lane_byte = lanes_i.data[i*8 +: 8];
			tag_wide = ({4'd0, acc_nxt.tag} * 20'd10) + {12'd0, lane_byte - 8'h30};
			if (lanes_i.tag_mask[i]) begin
				if (lane_byte >= 8'h30 && lane_byte <= 8'h39) begin
					acc_nxt.tag = (tag_wide > 20'h0FFFF) ? 16'hFFFF : tag_wide[15:0];
				end else begin
					acc_nxt.tag_err = 1'b1; // Tag number left as it was
				end
			end else if (lanes_i.value_mask[i]) begin
				acc_nxt.value_len = acc_nxt.value_len + 8'd1;
				acc_nxt.value_sum = acc_nxt.value_sum + lane_byte;
			end else if (lanes_i.soh_lane[i]) begin
				push = take_i;
				push_rec = acc_nxt;
				acc_nxt = '0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			acc_q <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			fq_cnt <= '0;
		end else begin
			if (take_i) begin
				acc_q <= acc_nxt;
			end
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (send_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			fq_cnt <= fq_cnt + push - send_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			fq_mem[wr_ptr] <= push_rec;
		end
	end

	assign fq_head_o = fq_mem[rd_ptr];
	assign fq_empty_o = (fq_cnt == '0);
	assign fq_room_o = (fq_cnt != (PTR_W + 1)'(`FIX_FQ_DEPTH));

endmodule

/* fix_parser_ctrl.sv */
// Input word queue, parse state, credit counters and sticky error
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_parser_ctrl (
	input logic clk_i,
	input logic rst_n_i,
	input logic word_valid_i,
	input logic [`FIX_WORD_W-1:0] word_i,
	input logic field_credit_i,
	input logic bad_i,
	input fix_pkg::fix_state_e exit_state_i,
	input logic fq_room_i,
	input logic fq_empty_i,
	output logic [`FIX_WORD_W-1:0] head_word_o,
	output fix_pkg::fix_state_e state_o,
	output logic take_o,
	output logic send_o,
	output logic in_credit_o,
	output logic field_valid_o,
	output logic parse_err_o
);

	localparam int PTR_W = $clog2(`FIX_IN_CREDITS);

	logic [`FIX_WORD_W-1:0] in_mem [`FIX_IN_CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] in_cnt;
	logic in_full;
	logic in_push;
	logic pop;
	logic [`FIX_OUT_CREDITS_W-1:0] out_credits;
	fix_pkg::fix_state_e state_q;
	logic in_credit_q;
	logic parse_err_q;

	assign in_full = (in_cnt == (PTR_W + 1)'(`FIX_IN_CREDITS));
	assign in_push = word_valid_i && !in_full; // Upstream credits keep this from overflowing
	assign pop = (in_cnt != '0) && fq_room_i;
	assign take_o = pop && !bad_i; // Bad word is dropped without folding
	assign send_o = !fq_empty_i && (out_credits != '0);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			in_cnt <= '0;
			out_credits <= '0;
			state_q <= fix_pkg::ST_TAG;
			in_credit_q <= 1'b0;
			parse_err_q <= 1'b0;
		end else begin
			if (in_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			in_cnt <= in_cnt + in_push - pop;
			out_credits <= out_credits + field_credit_i - send_o;
			if (take_o) begin
				state_q <= exit_state_i;
			end
			in_credit_q <= pop;
			if (pop && bad_i) begin
				parse_err_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_push) begin
			in_mem[wr_ptr] <= word_i;
		end
	end

	assign head_word_o = in_mem[rd_ptr];
	assign state_o = state_q;
	assign in_credit_o = in_credit_q;
	assign field_valid_o = send_o;
	assign parse_err_o = parse_err_q;

endmodule

/* fix_parser_top.sv */
// FIX parser top level with control, delimiter, splitter and builder
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_parser_top (
	input logic clk_i,
	input logic rst_n_i,
	input logic word_valid_i,
	input logic [`FIX_WORD_W-1:0] word_i,
	input logic field_credit_i,
	output logic in_credit_o,
	output logic field_valid_o,
	output fix_pkg::fix_field_t field_o,
	output logic parse_err_o
);

	logic [`FIX_WORD_W-1:0] head_word;
	fix_pkg::fix_state_e state;
	logic [`FIX_POS_W-1:0] soh_pos;
	logic [`FIX_POS_W-1:0] sep_pos;
	logic bad;
	fix_pkg::fix_lanes_t lanes;
	logic take;
	logic send;
	logic fq_room;
	logic fq_empty;

	fix_parser_ctrl i_ctrl (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.word_valid_i(word_valid_i),
		.word_i(word_i),
		.field_credit_i(field_credit_i),
		.bad_i(bad),
		.exit_state_i(lanes.exit_state),
		.fq_room_i(fq_room),
		.fq_empty_i(fq_empty),
		.head_word_o(head_word),
		.state_o(state),
		.take_o(take),
		.send_o(send),
		.in_credit_o(in_credit_o),
		.field_valid_o(field_valid_o),
		.parse_err_o(parse_err_o)
	);

	fix_delim_detect i_delim (
		.word_i(head_word),
		.soh_pos_o(soh_pos),
		.sep_pos_o(sep_pos),
		.bad_o(bad)
	);

	fix_lane_splitter i_split (
		.word_i(head_word),
		.soh_pos_i(soh_pos),
		.sep_pos_i(sep_pos),
		.state_i(state),
		.lanes_o(lanes)
	);

	fix_field_builder i_build (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.lanes_i(lanes),
		.take_i(take),
		.send_i(send),
		.fq_room_o(fq_room),
		.fq_head_o(field_o),
		.fq_empty_o(fq_empty)
	);

endmodule

/* fix_parser_assert.sv */
// Concurrent checks on downstream credits, reset outputs and input queue overflow
`timescale 1ns/1ps
`include "fix_defines.svh"

module fix_parser_assert (
	input logic clk_i,
	input logic rst_n_i,
	input logic field_credit_i,
	input logic field_valid_i,
	input logic in_credit_i,
	input logic word_valid_i,
	input logic in_full_i
);

	// Credits granted by downstream and not yet used, counted at the ports
	logic [`FIX_OUT_CREDITS_W:0] credits;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			credits <= '0;
		end else begin
			credits <= credits + field_credit_i - field_valid_i;
		end
	end

	a_send_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		field_valid_i |-> credits != '0)
		else $error("field_valid_o high with zero downstream credits");

	a_quiet_after_reset: assert property (@(posedge clk_i)
		!rst_n_i |=> !in_credit_i && !field_valid_i)
		else $error("in_credit_o or field_valid_o high right after reset");

	a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		word_valid_i |-> !in_full_i)
		else $error("word sent while the input queue is full");

endmodule

bind fix_parser_ctrl fix_parser_assert i_assert (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.field_credit_i(field_credit_i),
	.field_valid_i(field_valid_o),
	.in_credit_i(in_credit_o),
	.word_valid_i(word_valid_i),
	.in_full_i(in_full)
);

/* tb_fix_checker.sv */
// Field record scoreboard with expected queue and error counters
`timescale 1ns/1ps
`include "fix_defines.svh"

module tb_fix_checker (
	input logic clk_i,
	input logic rst_n_i,
	input logic field_valid_i,
	input fix_pkg::fix_field_t field_i
);

	fix_pkg::fix_field_t exp_q [$];
	int err_cnt = 0;
	int received = 0;

	task automatic expect_field(input fix_pkg::fix_field_t f);
		exp_q.push_back(f);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic compare(input string name, input int got, input int want);
		if (got != want) begin
			err_cnt++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
		end
	endtask

	always @(posedge clk_i) begin : check
		fix_pkg::fix_field_t want;
		if (rst_n_i && field_valid_i) begin
			received++;
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("record with tag %0d at %0t arrived when none was expected",
					field_i.tag, $time);
			end else begin
				want = exp_q.pop_front();
				compare("field_o.tag", int'(field_i.tag), int'(want.tag));
				compare("field_o.tag_err", int'(field_i.tag_err), int'(want.tag_err));
				compare("field_o.value_len", int'(field_i.value_len), int'(want.value_len));
				compare("field_o.value_sum", int'(field_i.value_sum), int'(want.value_sum));
			end
		end
	end

endmodule

/* tb_fix_parser.sv */
// FIX parser testbench with random message stimulus, credit handling and reference model
`timescale 1ns/1ps
`include "fix_defines.svh"

module tb_fix_parser;

	localparam int NUM_FIELDS = 80;
	localparam int OUT_MAX = (1 << `FIX_OUT_CREDITS_W) - 1;

	logic clk = 1'b0;
	logic rst_n;
	logic word_valid;
	logic [`FIX_WORD_W-1:0] word;
	logic field_credit = 1'b0;
	logic in_credit;
	logic field_valid;
	fix_pkg::fix_field_t field;
	logic parse_err;

	logic [31:0] rnd = 32'h8254;
	logic [31:0] crnd = 32'h8254;
	int cyc = 0;
	int sent = 0;
	int returned = 0;
	int granted = 0;
	int consumed = 0;
	int errors = 0;

	// Word being packed lane 3 first, and the bytes of the open field
	logic [`FIX_WORD_W-1:0] cur_word;
	int cur_n = 0;
	logic word_has_soh;
	logic word_has_sep;
	logic [7:0] fbuf [32];
	int flen = 0;

	fix_parser_top i_dut (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.word_valid_i(word_valid),
		.word_i(word),
		.field_credit_i(field_credit),
		.in_credit_o(in_credit),
		.field_valid_o(field_valid),
		.field_o(field),
		.parse_err_o(parse_err)
	);

	tb_fix_checker i_chk (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.field_valid_i(field_valid),
		.field_i(field)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_below(input int n);
		rnd = xorshift(rnd);
		return int'(rnd % 32'(n));
	endfunction

	// Expected record from the field bytes before SOH
	function automatic fix_pkg::fix_field_t ref_field(input logic [7:0] fb [32], input int n);
		fix_pkg::fix_field_t f;
		int tag;
		int digit;
		logic in_value;
		f = '0;
		tag = 0;
		in_value = 1'b0;
		for (int i = 0; i < n; i++) begin
			digit = int'(fb[i]) - 48;
			if (!in_value && fb[i] == `FIX_SEP) begin
				in_value = 1'b1;
			end else if (!in_value) begin
				if (digit >= 0 && digit <= 9) begin
					tag = (tag * 10 + digit > 65535) ? 65535 : tag * 10 + digit;
				end else begin
					f.tag_err = 1'b1; // Number keeps its digits so far
				end
			end else begin
				f.value_len = f.value_len + 8'd1;
				f.value_sum = f.value_sum + fb[i];
			end
		end
		f.tag = tag[15:0];
		return f;
	endfunction

	task automatic send_word(input logic [`FIX_WORD_W-1:0] w);
		int gap;
		gap = rand_below(4);
		repeat (gap) @(negedge clk);
		while (sent - returned >= `FIX_IN_CREDITS) @(negedge clk);
		word_valid = 1'b1;
		word = w;
		sent++;
		@(negedge clk);
		word_valid = 1'b0;
	endtask

	task automatic push_lane(input logic [7:0] b);
		cur_word[(3 - cur_n) * 8 +: 8] = b;
		cur_n++;
		if (b == `FIX_SOH) word_has_soh = 1'b1;
		if (b == `FIX_SEP) word_has_sep = 1'b1;
		if (cur_n == `FIX_LANES) begin
			send_word(cur_word);
			cur_n = 0;
			word_has_soh = 1'b0;
			word_has_sep = 1'b0;
		end
	endtask

	task automatic put_byte(input logic [7:0] b);
		logic [7:0] pad;
		pad = (b == `FIX_SEP) ? 8'h30 : 8'h50; // '0' joins the tag, 'P' joins the value
		while ((b == `FIX_SOH && word_has_soh) || (b == `FIX_SEP && word_has_sep)) begin
			fbuf[flen] = pad;
			flen++;
			push_lane(pad);
		end
		if (b == `FIX_SOH) begin
			i_chk.expect_field(ref_field(fbuf, flen));
			flen = 0;
		end else begin
			fbuf[flen] = b;
			flen++;
		end
		push_lane(b);
	endtask

	task automatic gen_field();
		int ntag;
		int nval;
		int letter_at;
		ntag = 1 + rand_below(5);
		letter_at = (rand_below(8) == 0) ? rand_below(ntag) : -1;
		for (int i = 0; i < ntag; i++) begin
			if (i == letter_at) put_byte(8'(8'h41 + rand_below(26)));
			else put_byte(8'(8'h30 + rand_below(10)));
		end
		put_byte(`FIX_SEP);
		nval = rand_below(10);
		for (int i = 0; i < nval; i++) put_byte(8'(8'h40 + rand_below(32)));
		put_byte(`FIX_SOH);
	endtask

	task automatic flush_word();
		while (cur_n != 0) put_byte(8'h30); // Leading zeros of the next tag
	endtask

	task automatic wait_drain();
		while (i_chk.pending() != 0) @(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	task automatic finish_run();
		$display("%0d checker errors, %0d testbench errors, %0d records received",
			i_chk.err_cnt, errors, i_chk.received);
		if (i_chk.err_cnt + errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// Credits come at random and are held back for 48 of every 128 cycles
	always @(negedge clk) begin
		crnd = xorshift(crnd);
		if (rst_n && (cyc % 128) < 80 && granted - consumed < OUT_MAX && crnd[4]) begin
			field_credit = 1'b1;
			granted++;
		end else begin
			field_credit = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cyc++;
			if (in_credit) returned++;
			if (field_valid) consumed++;
			if (returned > sent) begin
				errors++;
				$display("in_credit_o returned more credits than words sent at %0t", $time);
			end
			if (cyc > 40 * sent + 200) begin
				errors++;
				$display("timeout after %0d cycles with %0d words sent", cyc, sent);
				finish_run();
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		word_valid = 1'b0;
		word = '0;
		cur_word = '0;
		word_has_soh = 1'b0;
		word_has_sep = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int k = 0; k < NUM_FIELDS; k++) gen_field();
		flush_word();
		wait_drain();
		if (parse_err) begin
			errors++;
			$display("parse_err_o went high on well formed words");
		end
		// Two SOH bytes, so the fields "1" and "2" in it are lost and never expected
		send_word(32'h31_01_32_01);
		put_byte(8'h35);
		put_byte(`FIX_SEP);
		put_byte(8'h41);
		put_byte(`FIX_SOH);
		flush_word();
		wait_drain();
		if (!parse_err) begin
			errors++;
			$display("parse_err_o stayed low after a word with two SOH bytes");
		end
		finish_run();
	end

endmodule

/* vlog.f */
+incdir+.
fix_pkg.sv
fix_delim_detect.sv
fix_lane_splitter.sv
fix_field_builder.sv
fix_parser_ctrl.sv
fix_parser_top.sv
fix_parser_assert.sv
tb_fix_checker.sv
tb_fix_parser.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --assert -Wno-fatal -f vlog.f --top-module tb_fix_parser -Mdir obj_dir
	-./obj_dir/Vtb_fix_parser > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification failed" sim.log || ! grep -q "Verification passed" sim.log; then \
		echo "simulation did not pass"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
